/* include/id_consts.svh */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define DATA_W   32  // data word and pc width
`define REG_AW   5
`define NUM_REGS 32

`endif

/* logic/dual_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module dual_decode_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall_i,
    input  wire                 flush_i,
    input  wire [`DATA_W-1:0]   inst1_i,
    input  wire [`DATA_W-1:0]   inst2_i,
    input  wire [`DATA_W-1:0]   pc1_i,
    input  wire [`DATA_W-1:0]   pc2_i,
    input  wire                 valid1_i,
    input  wire                 valid2_i,
    input  wire                 ex_we1_i,
    input  wire [`REG_AW-1:0]   ex_waddr1_i,
    input  wire [`DATA_W-1:0]   ex_wdata1_i,
    input  wire                 ex_we2_i,
    input  wire [`REG_AW-1:0]   ex_waddr2_i,
    input  wire [`DATA_W-1:0]   ex_wdata2_i,
    input  wire                 mem_we1_i,
    input  wire [`REG_AW-1:0]   mem_waddr1_i,
    input  wire [`DATA_W-1:0]   mem_wdata1_i,
    input  wire                 mem_we2_i,
    input  wire [`REG_AW-1:0]   mem_waddr2_i,
    input  wire [`DATA_W-1:0]   mem_wdata2_i,
    input  wire                 wb_we1_i,
    input  wire [`REG_AW-1:0]   wb_waddr1_i,
    input  wire [`DATA_W-1:0]   wb_wdata1_i,
    input  wire                 wb_we2_i,
    input  wire [`REG_AW-1:0]   wb_waddr2_i,
    input  wire [`DATA_W-1:0]   wb_wdata2_i,
    output logic                issued_two_o,
    output logic                slot1_valid_o,
    output logic [`DATA_W-1:0]  slot1_pc_o,
    output logic [3:0]          slot1_alu_op_o,
    output logic [`DATA_W-1:0]  slot1_src_a_o,
    output logic [`DATA_W-1:0]  slot1_src_b_o,
    output logic [`DATA_W-1:0]  slot1_store_data_o,
    output logic                slot1_rf_we_o,
    output logic [`REG_AW-1:0]  slot1_waddr_o,
    output logic                slot1_mem_rd_o,
    output logic                slot1_mem_wr_o,
    output logic                slot2_valid_o,
    output logic [`DATA_W-1:0]  slot2_pc_o,
    output logic [3:0]          slot2_alu_op_o,
    output logic [`DATA_W-1:0]  slot2_src_a_o,
    output logic [`DATA_W-1:0]  slot2_src_b_o,
    output logic [`DATA_W-1:0]  slot2_store_data_o,
    output logic                slot2_rf_we_o,
    output logic [`REG_AW-1:0]  slot2_waddr_o,
    output logic                slot2_mem_rd_o,
    output logic                slot2_mem_wr_o
);
    import stage_pkg::*;

    decoded_t           dec1;
    decoded_t           dec2;
    slot_t              slot1_d;
    slot_t              slot2_d;
    slot_t              slot1_q;
    slot_t              slot2_q;
    logic [`DATA_W-1:0] rf_rdata [4];
    logic [`DATA_W-1:0] opnd [4];  // rs1, rt1, rs2, rt2

    fwd_if ex_fwd ();
    fwd_if mem_fwd ();
    fwd_if wb_fwd ();

    assign {ex_fwd.we1, ex_fwd.waddr1, ex_fwd.wdata1, ex_fwd.we2, ex_fwd.waddr2, ex_fwd.wdata2} =
        {ex_we1_i, ex_waddr1_i, ex_wdata1_i, ex_we2_i, ex_waddr2_i, ex_wdata2_i};
    assign {mem_fwd.we1, mem_fwd.waddr1, mem_fwd.wdata1,
            mem_fwd.we2, mem_fwd.waddr2, mem_fwd.wdata2} =
        {mem_we1_i, mem_waddr1_i, mem_wdata1_i, mem_we2_i, mem_waddr2_i, mem_wdata2_i};
    assign {wb_fwd.we1, wb_fwd.waddr1, wb_fwd.wdata1, wb_fwd.we2, wb_fwd.waddr2, wb_fwd.wdata2} =
        {wb_we1_i, wb_waddr1_i, wb_wdata1_i, wb_we2_i, wb_waddr2_i, wb_wdata2_i};

    inst_decoder u_dec1 (.inst_i(inst1_i), .dec_o(dec1));
    inst_decoder u_dec2 (.inst_i(inst2_i), .dec_o(dec2));

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb_fwd.sink),
        .raddr1_i (dec1.src_rs),
        .raddr2_i (dec1.src_rt),
        .raddr3_i (dec2.src_rs),
        .raddr4_i (dec2.src_rt),
        .rdata1_o (rf_rdata[0]),
        .rdata2_o (rf_rdata[1]),
        .rdata3_o (rf_rdata[2]),
        .rdata4_o (rf_rdata[3])
    );

    operand_bypass u_bypass (
        .ex         (ex_fwd.sink),
        .mem        (mem_fwd.sink),
        .wb         (wb_fwd.sink),
        .raddr1_i   (dec1.src_rs),
        .raddr2_i   (dec1.src_rt),
        .raddr3_i   (dec2.src_rs),
        .raddr4_i   (dec2.src_rt),
        .rf_data1_i (rf_rdata[0]),
        .rf_data2_i (rf_rdata[1]),
        .rf_data3_i (rf_rdata[2]),
        .rf_data4_i (rf_rdata[3]),
        .opnd1_o    (opnd[0]),
        .opnd2_o    (opnd[1]),
        .opnd3_o    (opnd[2]),
        .opnd4_o    (opnd[3])
    );

    issue_check u_issue (
        .dec1_i      (dec1),
        .dec2_i      (dec2),
        .valid1_i    (valid1_i),
        .valid2_i    (valid2_i),
        .stall_i     (stall_i),
        .issue_two_o (issued_two_o)
    );

    assign slot1_d = make_slot(valid1_i, pc1_i, dec1, opnd[0], opnd[1]);
    assign slot2_d = make_slot(valid2_i, pc2_i, dec2, opnd[2], opnd[3]);

    id_ex_latch u_latch (
        .clk         (clk),
        .rst         (rst),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .slot1_d_i   (slot1_d),
        .slot2_d_i   (slot2_d),
        .issue_two_i (issued_two_o),
        .slot1_q_o   (slot1_q),
        .slot2_q_o   (slot2_q)
    );

    // flattened in slot_t field order
    assign {slot1_valid_o, slot1_pc_o, slot1_alu_op_o, slot1_src_a_o, slot1_src_b_o,
            slot1_store_data_o, slot1_rf_we_o, slot1_waddr_o, slot1_mem_rd_o,
            slot1_mem_wr_o} = slot1_q;
    assign {slot2_valid_o, slot2_pc_o, slot2_alu_op_o, slot2_src_a_o, slot2_src_b_o,
            slot2_store_data_o, slot2_rf_we_o, slot2_waddr_o, slot2_mem_rd_o,
            slot2_mem_wr_o} = slot2_q;

endmodule

`default_nettype wire

/* logic/fwd_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

// result bus of one pipeline stage, both slots
interface fwd_if;

    logic                we1;
    logic [`REG_AW-1:0]  waddr1;
    logic [`DATA_W-1:0]  wdata1;
    logic                we2;   // slot 2 is younger
    logic [`REG_AW-1:0]  waddr2;
    logic [`DATA_W-1:0]  wdata2;

    modport src (
        output we1, waddr1, wdata1,
        output we2, waddr2, wdata2
    );

    modport sink (
        input we1, waddr1, wdata1,
        input we2, waddr2, wdata2
    );

endinterface

`default_nettype wire

/* logic/id_ex_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_latch (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  wire stage_pkg::slot_t slot1_d_i,
    input  wire stage_pkg::slot_t slot2_d_i,
    input  wire                   issue_two_i,
    output stage_pkg::slot_t      slot1_q_o,
    output stage_pkg::slot_t      slot2_q_o
);

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin  // flush beats stall
            slot1_q_o.valid <= 1'b0;
            slot2_q_o.valid <= 1'b0;
        end else if (!stall_i) begin
            slot1_q_o       <= slot1_d_i;
            slot2_q_o       <= slot2_d_i;
            slot2_q_o.valid <= slot2_d_i.valid && issue_two_i;
        end
    end

    a_flush_clears: assert property (
        @(posedge clk) flush_i |=> !slot1_q_o.valid && !slot2_q_o.valid
    );

    // dual issue only with both slots presented
    a_two_needs_v2: assert property (
        @(posedge clk) disable iff (rst) issue_two_i |-> slot1_d_i.valid && slot2_d_i.valid
    );

endmodule

`default_nettype wire

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module inst_decoder (
    input  wire isa_pkg::inst_word_u inst_i,
    output stage_pkg::decoded_t      dec_o
);
    import isa_pkg::*;

    logic [`DATA_W-1:0] imm_sext;
    logic [`DATA_W-1:0] imm_zext;
    logic [`DATA_W-1:0] imm_upper;
    logic [`DATA_W-1:0] imm_shamt;

    assign imm_sext  = {{(`DATA_W-16){inst_i.i.imm16[15]}}, inst_i.i.imm16};
    assign imm_zext  = {{(`DATA_W-16){1'b0}}, inst_i.i.imm16};
    assign imm_upper = {inst_i.i.imm16, {(`DATA_W-16){1'b0}}};
    assign imm_shamt = {{(`DATA_W-5){1'b0}}, inst_i.r.shamt};

    always_comb begin
        dec_o          = '0;
        dec_o.alu_op   = ALU_ADD;
        dec_o.src_rs   = inst_i.i.rs;
        dec_o.src_rt   = inst_i.i.rt;
        dec_o.rf_waddr = inst_i.i.rt;  // i-format dest
        case (inst_i.i.opcode)
            OP_SPECIAL: begin
                dec_o.rf_waddr = inst_i.r.rd;
                dec_o.rf_we    = 1'b1;
                dec_o.reads_rs = 1'b1;
                dec_o.reads_rt = 1'b1;
                case (inst_i.r.funct)
                    FN_ADDU: dec_o.alu_op = ALU_ADD;
                    FN_SUBU: dec_o.alu_op = ALU_SUB;
                    FN_AND:  dec_o.alu_op = ALU_AND;
                    FN_OR:   dec_o.alu_op = ALU_OR;
                    FN_XOR:  dec_o.alu_op = ALU_XOR;
                    FN_SLT:  dec_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        dec_o.alu_op   = ALU_SLL;
                        dec_o.reads_rs = 1'b0;
                        dec_o.use_imm  = 1'b1;  // shift amount rides in src_b
                        dec_o.imm32    = imm_shamt;
                    end
                    default: dec_o.illegal = 1'b1;
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                dec_o.reads_rs = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.imm32    = imm_sext;
                dec_o.rf_we    = (inst_i.i.opcode != OP_SW);
                dec_o.mem_rd   = (inst_i.i.opcode == OP_LW);
                dec_o.mem_wr   = (inst_i.i.opcode == OP_SW);
                dec_o.reads_rt = (inst_i.i.opcode == OP_SW);  // store data
            end
            OP_ORI: begin
                dec_o.alu_op   = ALU_OR;
                dec_o.reads_rs = 1'b1;
                dec_o.use_imm  = 1'b1;
                dec_o.imm32    = imm_zext;
                dec_o.rf_we    = 1'b1;
            end
            OP_LUI: begin
                dec_o.alu_op  = ALU_LUI;
                dec_o.use_imm = 1'b1;
                dec_o.imm32   = imm_upper;
                dec_o.rf_we   = 1'b1;
            end
            default: dec_o.illegal = 1'b1;
        endcase
        if (dec_o.illegal) begin
            dec_o.rf_we    = 1'b0;
            dec_o.reads_rs = 1'b0;
            dec_o.reads_rt = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // same 32 bits, two decode views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_word_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

`default_nettype wire

/* logic/issue_check.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_check (
    input  wire stage_pkg::decoded_t dec1_i,
    input  wire stage_pkg::decoded_t dec2_i,
    input  wire                      valid1_i,
    input  wire                      valid2_i,
    input  wire                      stall_i,
    output logic                     issue_two_o
);

    logic raw_hazard;
    logic mem_clash;

    // slot 2 reads what slot 1 writes
    assign raw_hazard = dec1_i.rf_we && (dec1_i.rf_waddr != '0) &&
                        ((dec2_i.reads_rs && dec2_i.src_rs == dec1_i.rf_waddr) ||
                         (dec2_i.reads_rt && dec2_i.src_rt == dec1_i.rf_waddr));

    assign mem_clash = (dec1_i.mem_rd || dec1_i.mem_wr) &&
                       (dec2_i.mem_rd || dec2_i.mem_wr);  // single data port

    assign issue_two_o = valid1_i && valid2_i && !stall_i &&
                         !dec1_i.illegal && !dec2_i.illegal &&
                         !raw_hazard && !mem_clash;

endmodule

`default_nettype wire

/* logic/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module operand_bypass (
    fwd_if.sink                ex,
    fwd_if.sink                mem,
    fwd_if.sink                wb,
    input  wire [`REG_AW-1:0]  raddr1_i,
    input  wire [`REG_AW-1:0]  raddr2_i,
    input  wire [`REG_AW-1:0]  raddr3_i,
    input  wire [`REG_AW-1:0]  raddr4_i,
    input  wire [`DATA_W-1:0]  rf_data1_i,
    input  wire [`DATA_W-1:0]  rf_data2_i,
    input  wire [`DATA_W-1:0]  rf_data3_i,
    input  wire [`DATA_W-1:0]  rf_data4_i,
    output logic [`DATA_W-1:0] opnd1_o,
    output logic [`DATA_W-1:0] opnd2_o,
    output logic [`DATA_W-1:0] opnd3_o,
    output logic [`DATA_W-1:0] opnd4_o
);

    // oldest source first, each later match overrides
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_AW-1:0] ra,
        input logic [`DATA_W-1:0] rf_d
    );
        logic [`DATA_W-1:0] v;
        v = rf_d;
        if (wb.we1  && wb.waddr1  == ra) v = wb.wdata1;
        if (wb.we2  && wb.waddr2  == ra) v = wb.wdata2;
        if (mem.we1 && mem.waddr1 == ra) v = mem.wdata1;
        if (mem.we2 && mem.waddr2 == ra) v = mem.wdata2;
        if (ex.we1  && ex.waddr1  == ra) v = ex.wdata1;
        if (ex.we2  && ex.waddr2  == ra) v = ex.wdata2;
        if (ra == '0) v = '0;  // r0 never forwarded
        return v;
    endfunction

    always_comb begin
        opnd1_o = pick(raddr1_i, rf_data1_i);
        opnd2_o = pick(raddr2_i, rf_data2_i);
        opnd3_o = pick(raddr3_i, rf_data3_i);
        opnd4_o = pick(raddr4_i, rf_data4_i);
    end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module regfile (
    input  wire                clk,
    input  wire                rst,
    fwd_if.sink                wb,
    input  wire [`REG_AW-1:0]  raddr1_i,
    input  wire [`REG_AW-1:0]  raddr2_i,
    input  wire [`REG_AW-1:0]  raddr3_i,
    input  wire [`REG_AW-1:0]  raddr4_i,
    output logic [`DATA_W-1:0] rdata1_o,
    output logic [`DATA_W-1:0] rdata2_o,
    output logic [`DATA_W-1:0] rdata3_o,
    output logic [`DATA_W-1:0] rdata4_o
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst)
            regs[0] <= '0;  // r0 holds zero from reset on
        if (wb.we1 && wb.waddr1 != '0)
            regs[wb.waddr1] <= wb.wdata1;
        if (wb.we2 && wb.waddr2 != '0)
            regs[wb.waddr2] <= wb.wdata2;  // port 2 wins a collision
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];
    assign rdata3_o = regs[raddr3_i];
    assign rdata4_o = regs[raddr4_i];

    property p_r0_zero(ra, rd);
        @(posedge clk) disable iff (rst) (ra == '0) |-> (rd == '0);
    endproperty

    a_r0_rd1: assert property (p_r0_zero(raddr1_i, rdata1_o));
    a_r0_rd2: assert property (p_r0_zero(raddr2_i, rdata2_o));
    a_r0_rd3: assert property (p_r0_zero(raddr3_i, rdata3_o));
    a_r0_rd4: assert property (p_r0_zero(raddr4_i, rdata4_o));

endmodule

`default_nettype wire

/* logic/stage_pkg.sv */
`default_nettype none
`include "id_consts.svh"

package stage_pkg;

    typedef struct packed {
        isa_pkg::alu_op_e    alu_op;
        logic                reads_rs;
        logic                reads_rt;
        logic                use_imm;
        logic [`DATA_W-1:0]  imm32;
        logic                rf_we;
        logic [`REG_AW-1:0]  rf_waddr;
        logic                mem_rd;
        logic                mem_wr;
        logic                illegal;
        logic [`REG_AW-1:0]  src_rs;  // source fields for hazard check
        logic [`REG_AW-1:0]  src_rt;
    } decoded_t;

    typedef struct packed {
        logic                valid;
        logic [`DATA_W-1:0]  pc;
        isa_pkg::alu_op_e    alu_op;
        logic [`DATA_W-1:0]  src_a;
        logic [`DATA_W-1:0]  src_b;
        logic [`DATA_W-1:0]  store_data;
        logic                rf_we;
        logic [`REG_AW-1:0]  rf_waddr;
        logic                mem_rd;
        logic                mem_wr;
    } slot_t;

    function automatic slot_t make_slot(
        input logic               valid,
        input logic [`DATA_W-1:0] pc,
        input decoded_t           dec,
        input logic [`DATA_W-1:0] rs_val,
        input logic [`DATA_W-1:0] rt_val
    );
        slot_t s;
        s.valid      = valid;
        s.pc         = pc;
        s.alu_op     = dec.alu_op;
        s.src_a      = (dec.alu_op == isa_pkg::ALU_SLL) ? rt_val : rs_val;  // sll shifts rt
        s.src_b      = dec.use_imm ? dec.imm32 : rt_val;
        s.store_data = rt_val;  // sw needs imm and data both
        s.rf_we      = dec.rf_we;
        s.rf_waddr   = dec.rf_waddr;
        s.mem_rd     = dec.mem_rd;
        s.mem_wr     = dec.mem_wr;
        return s;
    endfunction

endpackage

`default_nettype wire

/* sources.f */
+incdir+include
logic/isa_pkg.sv
logic/stage_pkg.sv
logic/fwd_if.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_bypass.sv
logic/issue_check.sv
logic/id_ex_latch.sv
logic/dual_decode_top.sv
verif/tb_checks.sv
verif/tb_dual_decode.sv

/* verif/tb_checks.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module tb_checks #(
    parameter int BUS_W = 2 * (1 + `REG_AW + `DATA_W)
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stall_i,
    input  wire                     flush_i,
    input  wire [1:0]               valid_i,  // {slot2, slot1}
    input  wire [`DATA_W-1:0]       inst1_i,
    input  wire [`DATA_W-1:0]       inst2_i,
    input  wire [`DATA_W-1:0]       pc1_i,
    input  wire [`DATA_W-1:0]       pc2_i,
    input  wire [BUS_W-1:0]         ex_i,
    input  wire [BUS_W-1:0]         mem_i,
    input  wire [BUS_W-1:0]         wb_i,
    input  wire                     issued_two_i,
    input  wire stage_pkg::slot_t   slot1_i,
    input  wire stage_pkg::slot_t   slot2_i,
    output int                      checks_o,
    output int                      passes_o,
    output int                      errors_o
);
    import isa_pkg::*;
    import stage_pkg::*;

    typedef struct packed {
        logic               we1;
        logic [`REG_AW-1:0] waddr1;
        logic [`DATA_W-1:0] wdata1;
        logic               we2;
        logic [`REG_AW-1:0] waddr2;
        logic [`DATA_W-1:0] wdata2;
    } bus_t;

    typedef struct packed {
        slot_t              s;
        logic               legal;
        logic               chk_a;  // src_a carries a real source
        logic               rd_rs;
        logic               rd_rt;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
    } ref_slot_t;

    bus_t               ex_b;
    bus_t               mem_b;
    bus_t               wb_b;
    logic [`DATA_W-1:0] shadow [`NUM_REGS];
    ref_slot_t          exp1;
    ref_slot_t          exp2;
    int                 n_checks = 0;
    int                 n_passes = 0;
    int                 n_errors = 0;

    assign ex_b     = ex_i;
    assign mem_b    = mem_i;
    assign wb_b     = wb_i;
    assign checks_o = n_checks;
    assign passes_o = n_passes;
    assign errors_o = n_errors;

    // youngest result first
    function automatic logic [`DATA_W-1:0] operand(input logic [`REG_AW-1:0] ra);
        if (ra == '0)
            return '0;
        if (ex_b.we2 && ex_b.waddr2 == ra)
            return ex_b.wdata2;
        if (ex_b.we1 && ex_b.waddr1 == ra)
            return ex_b.wdata1;
        if (mem_b.we2 && mem_b.waddr2 == ra)
            return mem_b.wdata2;
        if (mem_b.we1 && mem_b.waddr1 == ra)
            return mem_b.wdata1;
        if (wb_b.we2 && wb_b.waddr2 == ra)
            return wb_b.wdata2;
        if (wb_b.we1 && wb_b.waddr1 == ra)
            return wb_b.wdata1;
        return shadow[ra];
    endfunction

    function automatic ref_slot_t build_slot(
        input logic               valid,
        input logic [`DATA_W-1:0] pc,
        input logic [`DATA_W-1:0] w
    );
        ref_slot_t r;
        logic [`DATA_W-1:0] rt_v;
        r             = '0;
        r.rs          = w[25:21];
        r.rt          = w[20:16];
        rt_v          = operand(r.rt);
        r.s.valid     = valid;
        r.s.pc        = pc;
        r.s.alu_op    = ALU_ADD;
        r.s.src_a     = operand(r.rs);
        r.s.src_b     = {{16{w[15]}}, w[15:0]};
        r.s.store_data = rt_v;
        r.s.rf_we     = 1'b1;
        r.s.rf_waddr  = r.rt;
        r.legal       = 1'b1;
        r.chk_a       = 1'b1;
        r.rd_rs       = 1'b1;
        case (w[31:26])
            OP_SPECIAL: begin
                r.s.rf_waddr = w[15:11];
                r.s.src_b    = rt_v;
                r.rd_rt      = 1'b1;
                case (w[5:0])
                    FN_ADDU: r.s.alu_op = ALU_ADD;
                    FN_SUBU: r.s.alu_op = ALU_SUB;
                    FN_AND:  r.s.alu_op = ALU_AND;
                    FN_OR:   r.s.alu_op = ALU_OR;
                    FN_XOR:  r.s.alu_op = ALU_XOR;
                    FN_SLT:  r.s.alu_op = ALU_SLT;
                    FN_SLL: begin
                        r.s.alu_op = ALU_SLL;
                        r.s.src_a  = rt_v;  // shifted value is rt
                        r.s.src_b  = {27'b0, w[10:6]};
                        r.rd_rs    = 1'b0;
                    end
                    default: r.legal = 1'b0;
                endcase
            end
            OP_ADDIU: r.s.alu_op = ALU_ADD;
            OP_LW:    r.s.mem_rd = 1'b1;
            OP_SW: begin
                r.s.mem_wr = 1'b1;
                r.s.rf_we  = 1'b0;
                r.rd_rt    = 1'b1;
            end
            OP_ORI: begin
                r.s.alu_op = ALU_OR;
                r.s.src_b  = {16'b0, w[15:0]};
            end
            OP_LUI: begin
                r.s.alu_op = ALU_LUI;
                r.s.src_b  = {w[15:0], 16'b0};
                r.chk_a    = 1'b0;
                r.rd_rs    = 1'b0;
            end
            default: r.legal = 1'b0;
        endcase
        if (!r.legal) begin
            r.s.rf_we  = 1'b0;
            r.s.mem_rd = 1'b0;
            r.s.mem_wr = 1'b0;
        end
        return r;
    endfunction

    function automatic logic expect_two(input ref_slot_t a, input ref_slot_t b);
        logic raw;
        logic both_mem;
        raw = a.s.rf_we && a.s.rf_waddr != '0 &&
              ((b.rd_rs && b.rs == a.s.rf_waddr) || (b.rd_rt && b.rt == a.s.rf_waddr));
        both_mem = (a.s.mem_rd || a.s.mem_wr) && (b.s.mem_rd || b.s.mem_wr);
        return a.s.valid && b.s.valid && !stall_i && a.legal && b.legal && !raw && !both_mem;
    endfunction

    task automatic check_val(
        input string              name,
        input logic [`DATA_W-1:0] exp,
        input logic [`DATA_W-1:0] act
    );
        n_checks++;
        assert (act === exp)
            n_passes++;
        else begin
            n_errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_slot(input string tag, input ref_slot_t e, input slot_t got);
        check_val({tag, "_valid_o"}, e.s.valid, got.valid);
        if (e.s.valid) begin
            check_val({tag, "_pc_o"}, e.s.pc, got.pc);
            check_val({tag, "_rf_we_o"}, e.s.rf_we, got.rf_we);
            check_val({tag, "_mem_rd_o"}, e.s.mem_rd, got.mem_rd);
            check_val({tag, "_mem_wr_o"}, e.s.mem_wr, got.mem_wr);
            if (e.s.rf_we)
                check_val({tag, "_waddr_o"}, e.s.rf_waddr, got.rf_waddr);
            if (e.legal) begin
                check_val({tag, "_alu_op_o"}, e.s.alu_op, got.alu_op);
                check_val({tag, "_src_b_o"}, e.s.src_b, got.src_b);
                check_val({tag, "_store_data_o"}, e.s.store_data, got.store_data);
                if (e.chk_a)
                    check_val({tag, "_src_a_o"}, e.s.src_a, got.src_a);
            end
        end
    endtask

    always @(posedge clk) begin
        ref_slot_t n1;
        ref_slot_t n2;
        logic      two;
        n1  = build_slot(valid_i[0], pc1_i, inst1_i);
        n2  = build_slot(valid_i[1], pc2_i, inst2_i);
        two = expect_two(n1, n2);
        if (!rst) begin
            check_val("issued_two_o", two, issued_two_i);
            check_slot("slot1", exp1, slot1_i);
            check_slot("slot2", exp2, slot2_i);
        end
        if (rst || flush_i) begin
            exp1.s.valid <= 1'b0;
            exp2.s.valid <= 1'b0;
        end else if (!stall_i) begin
            n2.s.valid = n2.s.valid && two;  // second slot only on dual issue
            exp1 <= n1;
            exp2 <= n2;
        end
        if (wb_b.we1 && wb_b.waddr1 != '0)
            shadow[wb_b.waddr1] <= wb_b.wdata1;
        if (wb_b.we2 && wb_b.waddr2 != '0)
            shadow[wb_b.waddr2] <= wb_b.wdata2;  // port 2 wins
    end

endmodule

`default_nettype wire

/* verif/tb_dual_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "id_consts.svh"

module tb_dual_decode;
    import isa_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int RST_CYCLES  = 8;
    localparam int INIT_CYCLES = `NUM_REGS / 2;
    localparam int NUM_CYCLES  = 3000;

    logic               clk;
    logic               rst;
    logic               stall_i;
    logic               flush_i;
    logic               valid1_i;
    logic               valid2_i;
    logic [`DATA_W-1:0] inst1_i, inst2_i, pc1_i, pc2_i;
    logic               ex_we1_i, ex_we2_i, mem_we1_i, mem_we2_i, wb_we1_i, wb_we2_i;
    logic [`REG_AW-1:0] ex_waddr1_i, ex_waddr2_i, mem_waddr1_i, mem_waddr2_i;
    logic [`REG_AW-1:0] wb_waddr1_i, wb_waddr2_i;
    logic [`DATA_W-1:0] ex_wdata1_i, ex_wdata2_i, mem_wdata1_i, mem_wdata2_i;
    logic [`DATA_W-1:0] wb_wdata1_i, wb_wdata2_i;
    logic               issued_two_o;
    logic               slot1_valid_o, slot1_rf_we_o, slot1_mem_rd_o, slot1_mem_wr_o;
    logic               slot2_valid_o, slot2_rf_we_o, slot2_mem_rd_o, slot2_mem_wr_o;
    logic [`DATA_W-1:0] slot1_pc_o, slot1_src_a_o, slot1_src_b_o, slot1_store_data_o;
    logic [`DATA_W-1:0] slot2_pc_o, slot2_src_a_o, slot2_src_b_o, slot2_store_data_o;
    logic [3:0]         slot1_alu_op_o, slot2_alu_op_o;
    logic [`REG_AW-1:0] slot1_waddr_o, slot2_waddr_o;
    int                 checks;
    int                 passes;
    int                 errors;
    logic [`DATA_W-1:0] pc;

    dual_decode_top u_dut (.*);

    tb_checks u_checks (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .valid_i      ({valid2_i, valid1_i}),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .pc1_i        (pc1_i),
        .pc2_i        (pc2_i),
        .ex_i         ({ex_we1_i, ex_waddr1_i, ex_wdata1_i, ex_we2_i, ex_waddr2_i, ex_wdata2_i}),
        .mem_i        ({mem_we1_i, mem_waddr1_i, mem_wdata1_i,
                        mem_we2_i, mem_waddr2_i, mem_wdata2_i}),
        .wb_i         ({wb_we1_i, wb_waddr1_i, wb_wdata1_i, wb_we2_i, wb_waddr2_i, wb_wdata2_i}),
        .issued_two_i (issued_two_o),
        .slot1_i      ({slot1_valid_o, slot1_pc_o, slot1_alu_op_o, slot1_src_a_o, slot1_src_b_o,
                        slot1_store_data_o, slot1_rf_we_o, slot1_waddr_o, slot1_mem_rd_o,
                        slot1_mem_wr_o}),
        .slot2_i      ({slot2_valid_o, slot2_pc_o, slot2_alu_op_o, slot2_src_a_o, slot2_src_b_o,
                        slot2_store_data_o, slot2_rf_we_o, slot2_waddr_o, slot2_mem_rd_o,
                        slot2_mem_wr_o}),
        .checks_o     (checks),
        .passes_o     (passes),
        .errors_o     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((RST_CYCLES + INIT_CYCLES + NUM_CYCLES + 20) * CLK_NS);
        $display("watchdog expired before the test sequence finished");
        $display("Test failures found");
        $finish;
    end

    // small register range so hazards and bypass conflicts show up often
    function automatic logic [`DATA_W-1:0] rand_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        rs  = 5'($urandom % 8);
        rt  = 5'($urandom % 8);
        rd  = 5'($urandom % 8);
        imm = 16'($urandom);
        case ($urandom % 14)
            0:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
            1:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SUBU};
            2:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_AND};
            3:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_OR};
            4:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_XOR};
            5:  return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_SLT};
            6:  return {OP_SPECIAL, 5'd0, rt, rd, imm[4:0], FN_SLL};
            7:  return {OP_ADDIU, rs, rt, imm};
            8:  return {OP_ORI, rs, rt, imm};
            9:  return {OP_LUI, 5'd0, rt, imm};
            10: return {OP_LW, rs, rt, imm};
            11: return {OP_SW, rs, rt, imm};
            12: return {OP_SPECIAL, rs, rt, rd, 5'd0, 6'h3f};  // unknown funct
            default: return {6'h3f, rs, rt, imm};
        endcase
    endfunction

    task automatic set_bus_idle();
        {ex_we1_i, ex_waddr1_i, ex_wdata1_i, ex_we2_i, ex_waddr2_i, ex_wdata2_i} <= '0;
        {mem_we1_i, mem_waddr1_i, mem_wdata1_i, mem_we2_i, mem_waddr2_i, mem_wdata2_i} <= '0;
        {wb_we1_i, wb_waddr1_i, wb_wdata1_i, wb_we2_i, wb_waddr2_i, wb_wdata2_i} <= '0;
        {stall_i, flush_i, valid1_i, valid2_i} <= '0;
        {inst1_i, inst2_i, pc1_i, pc2_i} <= '0;
    endtask

    task automatic drive_random();
        valid1_i     <= ($urandom % 8) != 0;
        valid2_i     <= ($urandom % 8) != 0;
        inst1_i      <= rand_inst();
        inst2_i      <= rand_inst();
        pc1_i        <= pc;
        pc2_i        <= pc + 4;
        pc            = pc + 8;
        stall_i      <= ($urandom % 8) == 0;
        flush_i      <= ($urandom % 16) == 0;
        ex_we1_i     <= 1'($urandom % 2);
        ex_waddr1_i  <= 5'($urandom % 8);
        ex_wdata1_i  <= $urandom;
        ex_we2_i     <= 1'($urandom % 2);
        ex_waddr2_i  <= 5'($urandom % 8);
        ex_wdata2_i  <= $urandom;
        mem_we1_i    <= 1'($urandom % 2);
        mem_waddr1_i <= 5'($urandom % 8);
        mem_wdata1_i <= $urandom;
        mem_we2_i    <= 1'($urandom % 2);
        mem_waddr2_i <= 5'($urandom % 8);
        mem_wdata2_i <= $urandom;
        wb_we1_i     <= 1'($urandom % 2);
        wb_waddr1_i  <= 5'($urandom % 8);
        wb_wdata1_i  <= $urandom;
        wb_we2_i     <= 1'($urandom % 2);
        wb_waddr2_i  <= 5'($urandom % 8);
        wb_wdata2_i  <= $urandom;
    endtask

    initial begin
        void'($urandom(32'he1ee));
        pc = 32'h0040_0000;
        rst = 1'b1;
        set_bus_idle();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // every register gets a known value before it is read
        for (int r = 1; r < `NUM_REGS; r += 2) begin
            wb_we1_i    <= 1'b1;
            wb_waddr1_i <= 5'(r);
            wb_wdata1_i <= $urandom;
            wb_we2_i    <= (r + 1 < `NUM_REGS);
            wb_waddr2_i <= 5'(r + 1);
            wb_wdata2_i <= $urandom;
            @(posedge clk);
        end
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random();
            @(posedge clk);
        end
        set_bus_idle();
        repeat (3) @(posedge clk);
        $display("summary: %0d checks, %0d passed, %0d errors", checks, passes, errors);
        if (checks == 0)
            $display("checking assertions were not evaluated");
        if (errors == 0 && checks > 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
